//--- common/c64_loader_cfg.svh
//==================================================
// C64 loader configuration
// Widths, page-zero pointer values and timing
//==================================================
`ifndef C64_LOADER_CFG_SVH
`define C64_LOADER_CFG_SVH

// Bus widths
`define C64_ADDR_W 16
`define C64_DATA_W 8

// Page-zero pointer walk
`define C64_PTR_LAST 8'hFF
`define C64_BASIC_START_LO 8'h01
`define C64_BASIC_START_HI 8'h08

// RAM clear pass, kept short for simulation
`define C64_ERASE_LAST 16'h00FF
`define C64_ERASE_GAP 31

// Cycles per keystroke step
`define C64_KEY_STEP 16

// PS/2 set 2 scan codes
`define C64_KEY_R 8'h2D
`define C64_KEY_U 8'h3C
`define C64_KEY_N 8'h31
`define C64_KEY_RET 8'h5A

`endif

//--- common/c64_loader_pkg.sv
//==================================================
// C64 loader shared types
// Port structs and enums used across the loader
//==================================================
`include "c64_loader_cfg.svh"

package c64_loader_pkg;

	// Host download port
	typedef struct packed {
		logic download;
		logic wr;
		logic [7:0] index;
		logic [`C64_ADDR_W-1:0] addr;
		logic [`C64_DATA_W-1:0] data;
	} ioctl_t;

	// One RAM write in a free slot
	typedef struct packed {
		logic ce;
		logic [`C64_ADDR_W-1:0] addr;
		logic [`C64_DATA_W-1:0] data;
	} mem_wr_t;

	// Pending write of one source, held until granted
	typedef struct packed {
		logic req;
		logic [`C64_ADDR_W-1:0] addr;
		logic [`C64_DATA_W-1:0] data;
	} wr_req_t;

	// Keyboard word, strobe toggles per event
	typedef struct packed {
		logic strobe;
		logic pressed;
		logic ext;
		logic [7:0] code;
	} ps2_key_t;

	typedef enum logic [7:0] {
		IDX_BOOT_ROM = 8'd0,
		IDX_PRG = 8'd4
	} ioctl_index_e;

	typedef enum logic [1:0] {SRC_NONE, SRC_ERASE, SRC_INIT, SRC_PRG} wr_src_e;

	// Press steps land on odd codes
	typedef enum logic [3:0] {
		TYPE_IDLE, TYPE_R_DN, TYPE_R_UP, TYPE_U_DN, TYPE_U_UP,
		TYPE_N_DN, TYPE_N_UP, TYPE_RET_DN, TYPE_RET_UP
	} typer_step_e;

endpackage

//--- hdl/loader/prg_loader.sv
//==================================================
// PRG loader
// Takes the load address from the PRG header and
// requests one RAM write per data byte
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module prg_loader (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  c64_loader_pkg::ioctl_t    ioctl_i,
	input  logic                      grant_i,
	output c64_loader_pkg::wr_req_t   req_o,
	output logic                      wait_o,
	output logic [`C64_ADDR_W-1:0]    load_end_o,
	output logic                      load_done_o
);

	logic is_prg;
	logic download_d;
	logic end_pending;

	assign is_prg = (ioctl_i.index == c64_loader_pkg::IDX_PRG);

	// Host holds off while a byte is still waiting for its slot
	assign wait_o = req_o.req;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_o.req <= 1'b0;
			download_d <= 1'b0;
			end_pending <= 1'b0;
			load_done_o <= 1'b0;
		end else begin
			download_d <= ioctl_i.download;
			load_done_o <= 1'b0;

			// Request address doubles as the running load pointer
			if (req_o.req && grant_i) begin
				req_o.req <= 1'b0;
				req_o.addr <= req_o.addr + 1'b1;
			end

			if (ioctl_i.download && ioctl_i.wr && is_prg) begin
				if (ioctl_i.addr == 16'd0) begin
					req_o.addr[7:0] <= ioctl_i.data;
					load_end_o[7:0] <= ioctl_i.data;
				end else if (ioctl_i.addr == 16'd1) begin
					req_o.addr[`C64_ADDR_W-1:8] <= ioctl_i.data;
					load_end_o[`C64_ADDR_W-1:8] <= ioctl_i.data;
				end else begin
					req_o.req <= 1'b1;
					req_o.data <= ioctl_i.data;
					load_end_o <= load_end_o + 1'b1;
				end
			end

			// Done only once the last byte has reached RAM
			if (download_d && !ioctl_i.download && is_prg)
				end_pending <= 1'b1;
			if (end_pending && !req_o.req) begin
				end_pending <= 1'b0;
				load_done_o <= 1'b1;
			end
		end
	end

endmodule

//--- hdl/loader/basic_ptr_init.sv
//==================================================
// BASIC pointer init
// Walks page zero after a load and writes the
// pointer block as BASIC LOAD would leave it
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module basic_ptr_init (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      start_i,
	input  logic [`C64_ADDR_W-1:0]    load_end_i,
	input  logic                      grant_i,
	output c64_loader_pkg::wr_req_t   req_o,
	output logic                      done_o
);

	logic active;
	logic [7:0] walk_addr;
	logic walk_last;
	logic ptr_hit;
	logic [`C64_DATA_W-1:0] ptr_data;

	assign walk_last = (walk_addr == `C64_PTR_LAST);

	always_comb begin
		ptr_hit = 1'b1;
		ptr_data = '0;
		case (walk_addr)
			// Text start, untouched by LOAD
			8'h2B: ptr_data = `C64_BASIC_START_LO;
			8'h2C: ptr_data = `C64_BASIC_START_HI;
			// Save start stays cleared
			8'hAC, 8'hAD: ptr_data = '0;
			// Variables, arrays, strings and load end all point past the program
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_data = load_end_i[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_data = load_end_i[`C64_ADDR_W-1:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active <= 1'b0;
			req_o.req <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (start_i && !active) begin
				active <= 1'b1;
				walk_addr <= '0;
			end else if (req_o.req) begin
				if (grant_i) begin
					req_o.req <= 1'b0;
					if (walk_last) begin
						active <= 1'b0;
						done_o <= 1'b1;
					end else
						walk_addr <= walk_addr + 1'b1;
				end
			end else if (active) begin
				// Non-pointer bytes are skipped, one per cycle
				if (ptr_hit) begin
					req_o.req <= 1'b1;
					req_o.addr <= {{(`C64_ADDR_W-8){1'b0}}, walk_addr};
					req_o.data <= ptr_data;
				end else if (walk_last) begin
					active <= 1'b0;
					done_o <= 1'b1;
				end else
					walk_addr <= walk_addr + 1'b1;
			end
		end
	end

endmodule

//--- hdl/ram_eraser.sv
//==================================================
// RAM eraser
// Paced clear pass with an address-derived fill
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module ram_eraser (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      erase_i,
	input  logic                      grant_i,
	output c64_loader_pkg::wr_req_t   req_o
);

	localparam int GAP_W = $clog2(`C64_ERASE_GAP + 1);

	logic active;
	logic [GAP_W-1:0] gap_cnt;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active <= 1'b0;
			gap_cnt <= '0;
			req_o.req <= 1'b0;
		end else if (erase_i && !active) begin
			active <= 1'b1;
			gap_cnt <= '0;
			req_o.addr <= '0;
		end else if (req_o.req) begin
			if (grant_i) begin
				req_o.req <= 1'b0;
				gap_cnt <= GAP_W'(`C64_ERASE_GAP);
				if (req_o.addr == `C64_ERASE_LAST)
					active <= 1'b0;
				else
					req_o.addr <= req_o.addr + 1'b1;
			end
		end else if (active) begin
			if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
			else begin
				// Stripes of 64 bytes, like a powered-up C64 RAM
				req_o.req <= 1'b1;
				req_o.data <= {`C64_DATA_W{req_o.addr[6]}};
			end
		end
	end

endmodule

//--- hdl/io_slot_writer.sv
//==================================================
// IO slot writer
// Issues pending writes in free memory slots,
// erase first, then pointer init, then PRG data
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module io_slot_writer (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      io_cycle_i,
	input  c64_loader_pkg::wr_req_t   erase_req_i,
	input  c64_loader_pkg::wr_req_t   init_req_i,
	input  c64_loader_pkg::wr_req_t   prg_req_i,
	output c64_loader_pkg::mem_wr_t   mem_wr_o,
	output logic                      erase_grant_o,
	output logic                      init_grant_o,
	output logic                      prg_grant_o
);

	logic io_cycle_d;
	logic slot_fall;
	c64_loader_pkg::wr_src_e pick;
	c64_loader_pkg::wr_req_t sel_req;

	// Loader slot starts when the CPU side lets go of io_cycle
	assign slot_fall = io_cycle_d & ~io_cycle_i;

	always_comb begin
		pick = c64_loader_pkg::SRC_NONE;
		sel_req = prg_req_i;
		if (erase_req_i.req) begin
			pick = c64_loader_pkg::SRC_ERASE;
			sel_req = erase_req_i;
		end else if (init_req_i.req) begin
			pick = c64_loader_pkg::SRC_INIT;
			sel_req = init_req_i;
		end else if (prg_req_i.req)
			pick = c64_loader_pkg::SRC_PRG;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			mem_wr_o.ce <= 1'b0;
			erase_grant_o <= 1'b0;
			init_grant_o <= 1'b0;
			prg_grant_o <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			mem_wr_o.ce <= 1'b0;
			erase_grant_o <= 1'b0;
			init_grant_o <= 1'b0;
			prg_grant_o <= 1'b0;
			// One write per slot, grant pulses with ce
			if (slot_fall && pick != c64_loader_pkg::SRC_NONE) begin
				mem_wr_o.ce <= 1'b1;
				mem_wr_o.addr <= sel_req.addr;
				mem_wr_o.data <= sel_req.data;
				erase_grant_o <= (pick == c64_loader_pkg::SRC_ERASE);
				init_grant_o <= (pick == c64_loader_pkg::SRC_INIT);
				prg_grant_o <= (pick == c64_loader_pkg::SRC_PRG);
			end
		end
	end

endmodule

//--- hdl/autorun_typer.sv
//==================================================
// Autorun typer
// Types RUN and RETURN into the keyboard stream
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module autorun_typer (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  logic                      start_i,
	input  c64_loader_pkg::ps2_key_t  ps2_key_i,
	output c64_loader_pkg::ps2_key_t  key_o
);

	localparam int STEP_W = $clog2(`C64_KEY_STEP);

	c64_loader_pkg::typer_step_e step;
	c64_loader_pkg::typer_step_e step_next;
	logic [STEP_W-1:0] step_cnt;
	logic [7:0] step_code;
	logic step_pressed;

	always_comb begin
		case (step)
			c64_loader_pkg::TYPE_R_DN, c64_loader_pkg::TYPE_R_UP: step_code = `C64_KEY_R;
			c64_loader_pkg::TYPE_U_DN, c64_loader_pkg::TYPE_U_UP: step_code = `C64_KEY_U;
			c64_loader_pkg::TYPE_N_DN, c64_loader_pkg::TYPE_N_UP: step_code = `C64_KEY_N;
			default: step_code = `C64_KEY_RET;
		endcase
	end

	assign step_pressed = step[0];
	assign step_next = (step == c64_loader_pkg::TYPE_RET_UP) ? c64_loader_pkg::TYPE_IDLE :
		c64_loader_pkg::typer_step_e'(step + 4'd1);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			step <= c64_loader_pkg::TYPE_IDLE;
			step_cnt <= '0;
			key_o <= '0;
		end else if (start_i) begin
			step <= c64_loader_pkg::TYPE_R_DN;
			step_cnt <= '0;
		end else if (step == c64_loader_pkg::TYPE_IDLE)
			key_o <= ps2_key_i;
		else if (step_cnt == STEP_W'(`C64_KEY_STEP - 1)) begin
			// New key event, strobe flips
			step_cnt <= '0;
			step <= step_next;
			key_o.strobe <= ~key_o.strobe;
			key_o.pressed <= step_pressed;
			key_o.ext <= 1'b0;
			key_o.code <= step_code;
		end else
			step_cnt <= step_cnt + 1'b1;
	end

endmodule

//--- hdl/c64_loader_top.sv
//==================================================
// C64 loader top
// PRG load, pointer patch, RAM clear and autorun
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module c64_loader_top (
	input  logic                      clk_sys,
	input  logic                      reset_n,
	input  c64_loader_pkg::ioctl_t    ioctl_i,
	input  logic                      io_cycle_i,
	input  logic                      erase_i,
	input  c64_loader_pkg::ps2_key_t  ps2_key_i,
	output c64_loader_pkg::mem_wr_t   mem_wr_o,
	output logic                      ioctl_wait_o,
	output c64_loader_pkg::ps2_key_t  key_o
);

	c64_loader_pkg::wr_req_t prg_req;
	c64_loader_pkg::wr_req_t init_req;
	c64_loader_pkg::wr_req_t erase_req;
	logic prg_grant;
	logic init_grant;
	logic erase_grant;
	logic [`C64_ADDR_W-1:0] load_end;
	logic load_done;
	logic init_done;

	//==================================================
	// Write sources
	//==================================================
	prg_loader loader0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .ioctl_i(ioctl_i), .grant_i(prg_grant),
		.req_o(prg_req), .wait_o(ioctl_wait_o), .load_end_o(load_end),
		.load_done_o(load_done)
	);

	basic_ptr_init ptr_init0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .start_i(load_done),
		.load_end_i(load_end), .grant_i(init_grant), .req_o(init_req), .done_o(init_done)
	);

	ram_eraser eraser0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .erase_i(erase_i),
		.grant_i(erase_grant), .req_o(erase_req)
	);

	//==================================================
	// Slot arbitration and keyboard
	//==================================================
	io_slot_writer slot_writer0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .io_cycle_i(io_cycle_i),
		.erase_req_i(erase_req), .init_req_i(init_req), .prg_req_i(prg_req),
		.mem_wr_o(mem_wr_o), .erase_grant_o(erase_grant), .init_grant_o(init_grant),
		.prg_grant_o(prg_grant)
	);

	autorun_typer typer0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .start_i(init_done),
		.ps2_key_i(ps2_key_i), .key_o(key_o)
	);

endmodule

//--- verif/tb_c64_loader.sv
//==================================================
// C64 loader testbench
// Table-driven PRG loads, RAM clear and autorun
//==================================================
`timescale 1ns/1ns
`include "c64_loader_cfg.svh"

module tb_c64_loader;

	localparam int N_TESTS = 5;
	localparam int WAIT_LIMIT = 30000;

	logic clk_sys;
	logic reset_n;
	c64_loader_pkg::ioctl_t ioctl_i;
	logic io_cycle_i;
	logic erase_i;
	c64_loader_pkg::ps2_key_t ps2_key_i;
	c64_loader_pkg::mem_wr_t mem_wr_o;
	logic ioctl_wait_o;
	c64_loader_pkg::ps2_key_t key_o;

	logic [31:0] lfsr = 32'd81716;
	c64_loader_pkg::mem_wr_t main_q[$];
	c64_loader_pkg::mem_wr_t erase_q[$];
	int errors = 0;
	int checks = 0;
	int cycle = 0;
	int last_erase_cycle = 0;
	bit timed_out = 0;
	string cur_name = "reset";

	string test_name [N_TESTS];
	logic [15:0] test_load [N_TESTS];
	int test_count [N_TESTS];
	bit test_erase [N_TESTS];
	c64_loader_pkg::ps2_key_t key_tbl [4];
	logic [7:0] run_codes [4];

	c64_loader_top dut0 (
		.clk_sys(clk_sys), .reset_n(reset_n), .ioctl_i(ioctl_i), .io_cycle_i(io_cycle_i),
		.erase_i(erase_i), .ps2_key_i(ps2_key_i), .mem_wr_o(mem_wr_o),
		.ioctl_wait_o(ioctl_wait_o), .key_o(key_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Galois LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [7:0] next_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// Returns {hit, value} for the pointer block that BASIC LOAD leaves
	function automatic logic [8:0] ptr_rule(input logic [7:0] a, input logic [15:0] e);
		case (a)
			8'h2B: return {1'b1, `C64_BASIC_START_LO};
			8'h2C: return {1'b1, `C64_BASIC_START_HI};
			8'hAC, 8'hAD: return {1'b1, 8'h00};
			8'h2D, 8'h2F, 8'h31, 8'hAE: return {1'b1, e[7:0]};
			8'h2E, 8'h30, 8'h32, 8'hAF: return {1'b1, e[15:8]};
			default: return 9'h000;
		endcase
	endfunction

	// Slot pattern takes one LFSR bit per cycle
	initial begin
		io_cycle_i = 1'b0;
		forever begin
			@(negedge clk_sys);
			lfsr = lfsr_next(lfsr);
			io_cycle_i = lfsr[0];
		end
	end

	task automatic check_mem(input c64_loader_pkg::mem_wr_t exp,
		input c64_loader_pkg::mem_wr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected write %h, actual %h", cur_name, exp, act);
		end
	endtask

	task automatic check_key(input c64_loader_pkg::ps2_key_t exp,
		input c64_loader_pkg::ps2_key_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected key %h, actual %h", cur_name, exp, act);
		end
	endtask

	task automatic check_wait(input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s: expected ioctl_wait_o %b, actual %b", cur_name, exp, act);
		end
	endtask

	task automatic timeout_fail(input string what);
		errors++;
		timed_out = 1'b1;
		$display("%s: timed out %s", cur_name, what);
	endtask

	// Every ce pulse pops one expected write
	always @(negedge clk_sys) begin
		cycle++;
		if (reset_n && mem_wr_o.ce) begin
			if (erase_q.size() > 0 && mem_wr_o === erase_q[0]) begin
				erase_q.delete(0);
				checks++;
				last_erase_cycle = cycle;
			end else if (main_q.size() > 0) begin
				// Once the erase gap has run out the erase write must win the slot
				if (erase_q.size() > 0 && cycle - last_erase_cycle > `C64_ERASE_GAP + 2) begin
					errors++;
					$display("%s: write to %h took a slot while an erase write was due",
						cur_name, mem_wr_o.addr);
				end
				check_mem(main_q.pop_front(), mem_wr_o);
			end else if (erase_q.size() > 0)
				check_mem(erase_q.pop_front(), mem_wr_o);
			else begin
				errors++;
				$display("%s: unexpected RAM write to %h", cur_name, mem_wr_o.addr);
			end
		end
	end

	task automatic send_byte(input logic [15:0] a, input logic [7:0] d);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (ioctl_wait_o && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (ioctl_wait_o) begin
			timeout_fail("waiting for ioctl_wait_o to drop");
			return;
		end
		ioctl_i.wr = 1'b1;
		ioctl_i.addr = a;
		ioctl_i.data = d;
		@(negedge clk_sys);
		ioctl_i.wr = 1'b0;
		// Only data bytes leave a request behind
		check_wait(a > 16'd1, ioctl_wait_o);
	endtask

	task automatic check_pass_through();
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_sys);
			ps2_key_i = key_tbl[i];
			@(negedge clk_sys);
			check_key(key_tbl[i], key_o);
		end
	endtask

	task automatic watch_typing();
		c64_loader_pkg::ps2_key_t prev;
		c64_loader_pkg::ps2_key_t exp;
		logic strobe;
		int n;
		prev = key_o;
		// Strobe toggles onward from the last key passed through
		strobe = ps2_key_i.strobe;
		for (int s = 0; s < 8; s++) begin
			n = 0;
			while (key_o === prev && n < WAIT_LIMIT) begin
				@(negedge clk_sys);
				n++;
			end
			if (key_o === prev) begin
				timeout_fail("waiting for the next keystroke step");
				return;
			end
			if (s > 0 && n != `C64_KEY_STEP) begin
				errors++;
				$display("%s: keystroke step %0d came %0d cycles after the one before",
					cur_name, s, n);
			end
			strobe = ~strobe;
			exp.strobe = strobe;
			exp.pressed = (s % 2 == 0);
			exp.ext = 1'b0;
			exp.code = run_codes[s / 2];
			check_key(exp, key_o);
			prev = key_o;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((main_q.size() > 0 || erase_q.size() > 0) && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (main_q.size() > 0 || erase_q.size() > 0)
			timeout_fail("waiting for the remaining RAM writes");
	endtask

	task automatic run_test(input int t);
		logic [15:0] load;
		logic [15:0] end_a;
		logic [15:0] ea;
		logic [7:0] d;
		logic [8:0] pr;
		int err0;
		cur_name = test_name[t];
		err0 = errors;
		load = test_load[t];
		check_pass_through();
		if (test_erase[t]) begin
			for (int a = 0; a <= `C64_ERASE_LAST; a++) begin
				ea = 16'(a);
				erase_q.push_back({1'b1, ea, {`C64_DATA_W{ea[6]}}});
			end
			@(posedge clk_sys);
			last_erase_cycle = cycle;
			@(negedge clk_sys);
			erase_i = 1'b1;
			@(negedge clk_sys);
			erase_i = 1'b0;
		end
		if (test_count[t] > 0) begin
			@(negedge clk_sys);
			ioctl_i.download = 1'b1;
			ioctl_i.index = c64_loader_pkg::IDX_PRG;
			send_byte(16'd0, load[7:0]);
			send_byte(16'd1, load[15:8]);
			for (int i = 0; i < test_count[t] && !timed_out; i++) begin
				@(posedge clk_sys);
				d = next_byte();
				main_q.push_back({1'b1, load + 16'(i), d});
				send_byte(16'(i + 2), d);
			end
			if (!timed_out) begin
				@(negedge clk_sys);
				ioctl_i.download = 1'b0;
				end_a = load + 16'(test_count[t]);
				for (int a = 0; a < 256; a++) begin
					pr = ptr_rule(8'(a), end_a);
					if (pr[8])
						main_q.push_back({1'b1, 16'(a), pr[7:0]});
				end
				watch_typing();
			end
			if (!timed_out)
				check_pass_through();
		end
		if (!timed_out)
			wait_drain();
		$display("%s: %0d errors", cur_name, errors - err0);
	endtask

	initial begin
		test_name[0] = "prg_basic";
		test_load[0] = 16'h0801;
		test_count[0] = 5;
		test_erase[0] = 1'b0;
		test_name[1] = "prg_long";
		test_load[1] = 16'hC000;
		test_count[1] = 40;
		test_erase[1] = 1'b0;
		test_name[2] = "prg_wrap";
		test_load[2] = 16'hFFFE;
		test_count[2] = 6;
		test_erase[2] = 1'b0;
		test_name[3] = "erase_only";
		test_load[3] = 16'h0000;
		test_count[3] = 0;
		test_erase[3] = 1'b1;
		test_name[4] = "erase_and_prg";
		test_load[4] = 16'h2000;
		test_count[4] = 24;
		test_erase[4] = 1'b1;
		key_tbl[0] = {1'b1, 1'b1, 1'b0, 8'h1C};
		key_tbl[1] = {1'b0, 1'b0, 1'b0, 8'h1C};
		key_tbl[2] = {1'b1, 1'b1, 1'b1, 8'h75};
		key_tbl[3] = {1'b0, 1'b0, 1'b1, 8'h75};
		run_codes[0] = `C64_KEY_R;
		run_codes[1] = `C64_KEY_U;
		run_codes[2] = `C64_KEY_N;
		run_codes[3] = `C64_KEY_RET;

		reset_n = 1'b0;
		ioctl_i = '0;
		erase_i = 1'b0;
		ps2_key_i = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_n = 1'b1;

		for (int t = 0; t < N_TESTS && !timed_out; t++)
			run_test(t);

		$display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
		if (errors == 0 && !timed_out)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- sim.f
+incdir+common
common/c64_loader_pkg.sv
hdl/loader/prg_loader.sv
hdl/loader/basic_ptr_init.sv
hdl/ram_eraser.sv
hdl/io_slot_writer.sv
hdl/autorun_typer.sv
hdl/c64_loader_top.sv
verif/tb_c64_loader.sv
